//--- rtl/sprite_defs.svh
// sprite engine sizing; SPR_IDX_W must equal clog2(SPR_NUM), pixel memory wraps at 2**SPR_MEM_AW words
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// ####################################################################
// sprite count and indexing
// ####################################################################
`define SPR_NUM      4   // sprites in the engine
`define SPR_IDX_W    2   // width of a sprite number

// ####################################################################
// raster and address widths
// ####################################################################
`define SPR_COORD_W  10  // screen coordinate
`define SPR_NADDR_W  18  // nibble address into pixel memory
`define SPR_BASE_W   16  // base word address register

// ####################################################################
// memory and register map
// ####################################################################
`define SPR_MEM_AW   10  // pixel memory word address, depth 1024
`define SPR_REG_AW   4   // register slot select inside one sprite

`endif

//--- rtl/sprite_pkg.sv
// shared sprite types; widths come from sprite_defs.svh, register words are 16 bits wide
`default_nettype none
`include "sprite_defs.svh"

package sprite_pkg;

	typedef logic [`SPR_COORD_W-1:0] coord_t;  // screen x or y
	typedef logic [`SPR_NADDR_W-1:0] naddr_t;  // nibble address

	typedef struct packed {
		logic [3:0] pal_hi;  // palette region
		logic [3:0] color;   // chunky pixel, 0 = transparent
	} pal_index_t;

	// register slots inside one sprite, 7..15 unused
	typedef enum logic [`SPR_REG_AW-1:0] {
		REG_X      = 4'd0,
		REG_Y      = 4'd1,
		REG_BASE   = 4'd2,
		REG_FLAGS  = 4'd3,
		REG_PAL_HI = 4'd4,
		REG_X_END  = 4'd5,
		REG_Y_END  = 4'd6
	} reg_sel_e;

	typedef struct packed {
		logic [2:0] rsvd_hi;     // bits 6:4
		logic       stride_256;  // bit 3, row pitch 256 else 128
		logic [1:0] rsvd_lo;     // bits 2:1
		logic       enable;      // bit 0
	} sprite_flags_t;

	// one host data word, viewed per slot
	typedef union packed {
		logic [15:0] raw;  // BASE, low nibble for PAL_HI
		struct packed {
			logic [5:0] pad;
			coord_t     coord;
		} coord_v;         // X, Y, X_END, Y_END
		struct packed {
			logic [8:0]    pad;
			sprite_flags_t flags;
		} flags_v;         // FLAGS
	} reg_word_u;

endpackage

`default_nettype wire

//--- rtl/sprite_cfg_if.sv
// one sprite's configuration, static between host writes; regs side drives, locate side reads
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

interface sprite_cfg_if;

	sprite_pkg::coord_t          x;       // left edge, inclusive
	sprite_pkg::coord_t          y;       // top edge, inclusive
	sprite_pkg::coord_t          x_end;   // right edge, exclusive
	sprite_pkg::coord_t          y_end;   // bottom edge, exclusive
	logic [`SPR_BASE_W-1:0]      base;    // word address of pixel 0
	sprite_pkg::sprite_flags_t   flags;
	logic [3:0]                  pal_hi;  // palette high nibble

	modport regs (
		output x, y, x_end, y_end, base, flags, pal_hi
	);

	modport locate (
		input x, y, x_end, y_end, base, flags, pal_hi
	);

endinterface

`default_nettype wire

//--- rtl/sprite_regs.sv
// write-only sprite registers; wr must already be qualified for this sprite, slots 7..15 are ignored
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

module sprite_regs
(
	input  wire logic                 CLK,
	input  wire logic                 RSTb,
	input  wire logic                 wr,       // strobe for this sprite only
	input  wire sprite_pkg::reg_sel_e reg_sel,  // slot from host address
	input  wire sprite_pkg::reg_word_u data,    // host data word
	sprite_cfg_if.regs                cfg
);

	sprite_pkg::coord_t         x_r;
	sprite_pkg::coord_t         y_r;
	sprite_pkg::coord_t         x_end_r;
	sprite_pkg::coord_t         y_end_r;
	logic [`SPR_BASE_W-1:0]     base_r;
	sprite_pkg::sprite_flags_t  flags_r;
	logic [3:0]                 pal_hi_r;

	// ####################################################################
	// register file, one slot per write
	// ####################################################################
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			x_r      <= '0;  // zero flags keeps sprite disabled
			y_r      <= '0;
			x_end_r  <= '0;
			y_end_r  <= '0;
			base_r   <= '0;
			flags_r  <= '0;
			pal_hi_r <= '0;
		end
		else if (wr)
		begin
			case (reg_sel)
				sprite_pkg::REG_X:      x_r      <= data.coord_v.coord;
				sprite_pkg::REG_Y:      y_r      <= data.coord_v.coord;
				sprite_pkg::REG_BASE:   base_r   <= data.raw;           // full word
				sprite_pkg::REG_FLAGS:  flags_r  <= data.flags_v.flags;
				sprite_pkg::REG_PAL_HI: pal_hi_r <= data.raw[3:0];      // low nibble only
				sprite_pkg::REG_X_END:  x_end_r  <= data.coord_v.coord;
				sprite_pkg::REG_Y_END:  y_end_r  <= data.coord_v.coord;
				default: ;                                              // unused slot
			endcase
		end
	end

	// ####################################################################
	// out to the locator
	// ####################################################################
	assign cfg.x      = x_r;
	assign cfg.y      = y_r;
	assign cfg.x_end  = x_end_r;
	assign cfg.y_end  = y_end_r;
	assign cfg.base   = base_r;
	assign cfg.flags  = flags_r;
	assign cfg.pal_hi = pal_hi_r;

endmodule

`default_nettype wire

//--- rtl/sprite_locate.sv
// hit test and nibble address, one cycle; offsets truncate to 6 bits so a sprite is at most 64x64
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

module sprite_locate
(
	input  wire logic                 CLK,
	input  wire logic                 RSTb,
	sprite_cfg_if.locate              cfg,
	input  wire sprite_pkg::coord_t   display_x,
	input  wire sprite_pkg::coord_t   display_y,
	output logic                      active,  // raster inside this sprite
	output sprite_pkg::naddr_t        naddr,   // nibble to fetch
	output logic [3:0]                pal_hi   // tag, same pixel as naddr
);

	logic                in_x;
	logic                in_y;
	logic                hit;
	logic [5:0]          u;         // column inside sprite
	logic [5:0]          v;         // row inside sprite
	sprite_pkg::naddr_t  row_off;
	sprite_pkg::naddr_t  naddr_next;

	// ####################################################################
	// hit test, half-open rectangle
	// ####################################################################
	assign in_x = (display_x >= cfg.x) && (display_x < cfg.x_end);
	assign in_y = (display_y >= cfg.y) && (display_y < cfg.y_end);
	assign hit  = cfg.flags.enable && in_x && in_y;

	// ####################################################################
	// address generation
	// ####################################################################
	assign u = 6'(display_x - cfg.x);  // low bits only
	assign v = 6'(display_y - cfg.y);

	always_comb
	begin
		if (cfg.flags.stride_256)
			row_off = sprite_pkg::naddr_t'({v, 8'b0});  // 256 pixels per row
		else
			row_off = sprite_pkg::naddr_t'({v, 7'b0});  // 128 pixels per row
		// word base to nibbles, wraps at 2**18
		naddr_next = sprite_pkg::naddr_t'({cfg.base, 2'b00}) + row_off
			+ sprite_pkg::naddr_t'(u);
	end

	// ####################################################################
	// pipeline stage 1
	// ####################################################################
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			active <= 1'b0;
		else
			active <= hit;
	end

	always_ff @(posedge CLK)
	begin
		naddr  <= naddr_next;  // every cycle, hit or not
		pal_hi <= cfg.pal_hi;  // travels with its address
	end

endmodule

`default_nettype wire

//--- rtl/sprite_pixel_mem.sv
// shared pixel RAM, one write port and SPR_NUM read ports; write and read of one word give old data
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

module sprite_pixel_mem
(
	input  wire logic                                CLK,
	input  wire logic                                RSTb,
	input  wire logic                                mem_wr,
	input  wire logic [15:0]                         mem_addr,   // wraps to depth
	input  wire logic [15:0]                         mem_data,   // four pixels
	input  wire logic [`SPR_NUM-1:0]                 rd_active,
	input  wire sprite_pkg::naddr_t [`SPR_NUM-1:0]   rd_naddr,
	input  wire logic [`SPR_NUM-1:0][3:0]            rd_pal_hi,
	output logic [`SPR_NUM-1:0]                      hit_q,
	output logic [`SPR_NUM-1:0][3:0]                 nibble,
	output logic [`SPR_NUM-1:0][3:0]                 pal_hi_q
);

	localparam int DEPTH = 2 ** `SPR_MEM_AW;

	logic [15:0] mem [DEPTH];                  // pixel words, no reset
	logic [`SPR_NUM-1:0][15:0] rd_word;        // registered word per port
	logic [`SPR_NUM-1:0][1:0]  rd_sel;         // registered nibble select

	// ####################################################################
	// host write port
	// ####################################################################
	always_ff @(posedge CLK)
	begin
		if (mem_wr)
			mem[mem_addr[`SPR_MEM_AW-1:0]] <= mem_data;
	end

	// ####################################################################
	// read ports, stage 2
	// ####################################################################
	always_ff @(posedge CLK)
	begin
		for (int i = 0; i < `SPR_NUM; i++)
		begin
			rd_word[i]  <= mem[rd_naddr[i][`SPR_MEM_AW+1:2]];  // word index, wrapped
			rd_sel[i]   <= rd_naddr[i][1:0];                 // nibble in word
			pal_hi_q[i] <= rd_pal_hi[i];                     // tag follows data
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			hit_q <= '0;
		else
			hit_q <= rd_active;
	end

	// nibble 0 sits in bits 3:0
	always_comb
	begin
		for (int i = 0; i < `SPR_NUM; i++)
			nibble[i] = rd_word[i][rd_sel[i]*4 +: 4];
	end

endmodule

`default_nettype wire

//--- rtl/sprite_mixer.sv
// priority mixer; colour 0 is transparent and the lowest sprite number wins, output registered
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

module sprite_mixer
(
	input  wire logic                        CLK,
	input  wire logic                        RSTb,
	input  wire logic [`SPR_NUM-1:0]         hit_q,
	input  wire logic [`SPR_NUM-1:0][3:0]    nibble,
	input  wire logic [`SPR_NUM-1:0][3:0]    pal_hi_q,
	output logic                             pix_hit,
	output sprite_pkg::pal_index_t           pix_index,
	output logic [`SPR_IDX_W-1:0]            pix_sprite
);

	logic [`SPR_NUM-1:0]      opaque;   // hit and visible colour
	logic                     any_hit;
	logic [`SPR_IDX_W-1:0]    win_idx;
	sprite_pkg::pal_index_t   win_pix;

	// ####################################################################
	// transparency and priority
	// ####################################################################
	always_comb
	begin
		for (int i = 0; i < `SPR_NUM; i++)
			opaque[i] = hit_q[i] && (nibble[i] != 4'd0);
	end

	always_comb
	begin
		any_hit = |opaque;
		win_idx = '0;   // nothing opaque gives zeros
		win_pix = '0;
		// walk from the top so the lowest opaque sprite is kept
		for (int i = `SPR_NUM-1; i >= 0; i--)
		begin
			if (opaque[i])
			begin
				win_idx        = `SPR_IDX_W'(i);
				win_pix.pal_hi = pal_hi_q[i];
				win_pix.color  = nibble[i];
			end
		end
	end

	// ####################################################################
	// output stage 3
	// ####################################################################
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			pix_hit    <= 1'b0;
			pix_index  <= '0;
			pix_sprite <= '0;
		end
		else
		begin
			pix_hit    <= any_hit;
			pix_index  <= win_pix;
			pix_sprite <= win_idx;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sprite_engine.sv
// sprite overlay top; 3-cycle latency, one pixel per cycle, registers write-only, no back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

module sprite_engine
(
	input  wire logic                               CLK,
	input  wire logic                               RSTb,
	input  wire logic                               WR,
	input  wire logic [`SPR_IDX_W+`SPR_REG_AW-1:0]  ADDRESS,   // {sprite, slot}
	input  wire logic [15:0]                        DATA_IN,
	input  wire logic                               MEM_WR,
	input  wire logic [15:0]                        MEM_ADDR,
	input  wire logic [15:0]                        MEM_DATA,
	input  wire sprite_pkg::coord_t                 display_x,
	input  wire sprite_pkg::coord_t                 display_y,
	output logic                                    PIX_HIT,
	output sprite_pkg::pal_index_t                  PIX_INDEX,
	output logic [`SPR_IDX_W-1:0]                   PIX_SPRITE
);

	sprite_pkg::reg_word_u                  data_word;  // DATA_IN as a union
	sprite_pkg::reg_sel_e                   reg_sel;
	logic [`SPR_NUM-1:0]                    loc_active; // stage 1
	sprite_pkg::naddr_t [`SPR_NUM-1:0]      loc_naddr;
	logic [`SPR_NUM-1:0][3:0]               loc_pal_hi;
	logic [`SPR_NUM-1:0]                    mem_hit_q;  // stage 2
	logic [`SPR_NUM-1:0][3:0]               mem_nibble;
	logic [`SPR_NUM-1:0][3:0]               mem_pal_hi_q;

	assign data_word = DATA_IN;
	assign reg_sel   = sprite_pkg::reg_sel_e'(ADDRESS[`SPR_REG_AW-1:0]);

	// ####################################################################
	// per-sprite registers and locators
	// ####################################################################
	for (genvar g = 0; g < `SPR_NUM; g++)
	begin : g_spr
		logic spr_wr;
		sprite_cfg_if cfg_bus ();

		// sprite field decode
		assign spr_wr = WR && (ADDRESS[`SPR_IDX_W+`SPR_REG_AW-1:`SPR_REG_AW] == `SPR_IDX_W'(g));

		sprite_regs u_regs (
			.CLK(CLK), .RSTb(RSTb), .wr(spr_wr), .reg_sel(reg_sel),
			.data(data_word), .cfg(cfg_bus)
		);

		sprite_locate u_locate (
			.CLK(CLK), .RSTb(RSTb), .cfg(cfg_bus),
			.display_x(display_x), .display_y(display_y),
			.active(loc_active[g]), .naddr(loc_naddr[g]), .pal_hi(loc_pal_hi[g])
		);
	end

	// ####################################################################
	// shared memory and mixer
	// ####################################################################
	sprite_pixel_mem u_mem (
		.CLK(CLK), .RSTb(RSTb), .mem_wr(MEM_WR), .mem_addr(MEM_ADDR), .mem_data(MEM_DATA),
		.rd_active(loc_active), .rd_naddr(loc_naddr), .rd_pal_hi(loc_pal_hi),
		.hit_q(mem_hit_q), .nibble(mem_nibble), .pal_hi_q(mem_pal_hi_q)
	);

	sprite_mixer u_mixer (
		.CLK(CLK), .RSTb(RSTb),
		.hit_q(mem_hit_q), .nibble(mem_nibble), .pal_hi_q(mem_pal_hi_q),
		.pix_hit(PIX_HIT), .pix_index(PIX_INDEX), .pix_sprite(PIX_SPRITE)
	);

endmodule

`default_nettype wire

//--- verif/sprite_engine_tb.sv
// self-checking testbench; the model tracks every host write, so memory may be refilled with sprites live
`timescale 1ns/1ps
`default_nettype none
`include "sprite_defs.svh"

module sprite_engine_tb;

	localparam int DEPTH    = 2 ** `SPR_MEM_AW;
	localparam int PLAN_CYC = 8 + 200 + (DEPTH + 7 + 500) + (DEPTH + 14 + 600)
		+ (DEPTH + 14 + 400) + (28 + 500) + (400 + 11) + 5;
	localparam int LIMIT    = PLAN_CYC + PLAN_CYC / 10;  // ten percent over plan

	logic CLK = 1'b0;
	logic RSTb, WR, MEM_WR;
	logic [`SPR_IDX_W+`SPR_REG_AW-1:0] ADDRESS;
	logic [15:0] DATA_IN, MEM_ADDR, MEM_DATA;
	sprite_pkg::coord_t display_x, display_y;
	logic PIX_HIT;
	sprite_pkg::pal_index_t PIX_INDEX;
	logic [`SPR_IDX_W-1:0] PIX_SPRITE;

	logic [31:0] lfsr = 32'd72140;
	int coord_bits, checks, errors, mark_checks, mark_errors;
	int cycles = 0;
	int m_x [`SPR_NUM];  // model registers
	int m_y [`SPR_NUM];
	int m_xe [`SPR_NUM];
	int m_ye [`SPR_NUM];
	int m_base [`SPR_NUM];
	logic [6:0] m_flags [`SPR_NUM];
	logic [3:0] m_pal [`SPR_NUM];
	logic [15:0] m_mem [DEPTH];  // model pixel memory
	logic exp_hit [$];  // three deep, one per pixel in flight
	sprite_pkg::pal_index_t exp_idx [$];
	logic [`SPR_IDX_W-1:0] exp_spr [$];

	sprite_engine DUT (
		.CLK(CLK), .RSTb(RSTb), .WR(WR), .ADDRESS(ADDRESS), .DATA_IN(DATA_IN),
		.MEM_WR(MEM_WR), .MEM_ADDR(MEM_ADDR), .MEM_DATA(MEM_DATA),
		.display_x(display_x), .display_y(display_y),
		.PIX_HIT(PIX_HIT), .PIX_INDEX(PIX_INDEX), .PIX_SPRITE(PIX_SPRITE)
	);

	always #2 CLK = ~CLK;  // 4 ns period

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycles > LIMIT)
		begin
			$display("run stopped after %0d cycles without finishing the tests", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ####################################################################
	// random source, fibonacci lfsr x^32+x^22+x^2+x+1
	// ####################################################################
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < n; k++)
		begin
			r    = {r[30:0], lfsr[31]};  // one step per bit
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [15:0] coord_word(input int c);
		logic [15:0] w;
		w      = 16'(rand_bits(16));  // junk in the pad bits
		w[9:0] = c[9:0];
		return w;
	endfunction

	// ####################################################################
	// compare tasks
	// ####################################################################
	task automatic check_index(input sprite_pkg::pal_index_t got, input sprite_pkg::pal_index_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH PIX_INDEX got %h expected %h", got, exp);
		end
	endtask

	task automatic check_sprite(input logic [`SPR_IDX_W-1:0] got, input logic [`SPR_IDX_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH PIX_SPRITE got %h expected %h", got, exp);
		end
	endtask

	task automatic check_hit(input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH PIX_HIT got %h expected %h", got, exp);
		end
	endtask

	// ####################################################################
	// reference model
	// ####################################################################
	task automatic model_pixel(input int px, input int py);
		int na, nib;
		logic found;
		logic [15:0] w;
		sprite_pkg::pal_index_t idx;
		logic [`SPR_IDX_W-1:0] spr;
		found = 1'b0;
		idx   = '0;
		spr   = '0;
		for (int i = 0; i < `SPR_NUM; i++)  // lowest index first
		begin
			if (!found && m_flags[i][0] && px >= m_x[i] && px < m_xe[i]
				&& py >= m_y[i] && py < m_ye[i])
			begin
				na  = m_base[i] * 4 + ((py - m_y[i]) % 64) * (m_flags[i][3] ? 256 : 128)
					+ (px - m_x[i]) % 64;
				na  = na % (1 << `SPR_NADDR_W);
				w   = m_mem[(na / 4) % DEPTH];
				nib = (w >> ((na % 4) * 4)) & 15;
				if (nib != 0)  // colour 0 lets lower sprites through
				begin
					found = 1'b1;
					spr   = `SPR_IDX_W'(i);
					idx   = {m_pal[i], nib[3:0]};
				end
			end
		end
		exp_hit.push_back(found);
		exp_idx.push_back(idx);
		exp_spr.push_back(spr);
	endtask

	task automatic apply_reg(input logic [5:0] addr, input logic [15:0] data);
		int s;
		s = addr[5:4];
		case (addr[3:0])
			4'd0: m_x[s]     = data[9:0];
			4'd1: m_y[s]     = data[9:0];
			4'd2: m_base[s]  = data;
			4'd3: m_flags[s] = data[6:0];
			4'd4: m_pal[s]   = data[3:0];
			4'd5: m_xe[s]    = data[9:0];
			4'd6: m_ye[s]    = data[9:0];
			default: ;  // slots 7..15 do nothing
		endcase
	endtask

	// ####################################################################
	// one pixel per falling edge, outputs checked three pixels later
	// ####################################################################
	task automatic step_pixel(input logic wr, input logic [5:0] addr, input logic [15:0] data,
		input logic mem_wr, input logic [15:0] maddr, input logic [15:0] mdata);
		sprite_pkg::coord_t px;
		sprite_pkg::coord_t py;
		@(negedge CLK);
		if (exp_hit.size() == 3)
		begin
			check_hit(PIX_HIT, exp_hit.pop_front());
			check_index(PIX_INDEX, exp_idx.pop_front());
			check_sprite(PIX_SPRITE, exp_spr.pop_front());
		end
		px        = sprite_pkg::coord_t'(rand_bits(coord_bits));
		py        = sprite_pkg::coord_t'(rand_bits(coord_bits));
		WR        = wr;
		ADDRESS   = addr;
		DATA_IN   = data;
		MEM_WR    = mem_wr;
		MEM_ADDR  = maddr;
		MEM_DATA  = mdata;
		display_x = px;
		display_y = py;
		if (mem_wr)
			m_mem[maddr[`SPR_MEM_AW-1:0]] = mdata;  // read of this pixel sees it
		model_pixel(px, py);
		if (wr)
			apply_reg(addr, data);  // old config for this pixel
	endtask

	task automatic idle_pixel();
		step_pixel(1'b0, 6'd0, 16'd0, 1'b0, 16'd0, 16'd0);
	endtask

	task automatic write_reg(input int idx, input int slot, input logic [15:0] data);
		step_pixel(1'b1, {idx[1:0], slot[3:0]}, data, 1'b0, 16'd0, 16'd0);
	endtask

	// mode 0 opaque pattern, 1 random, 2 about half transparent
	task automatic fill_mem(input int mode);
		logic [15:0] w;
		logic [15:0] a;
		for (int i = 0; i < DEPTH; i++)
		begin
			w = 16'(rand_bits(16));
			for (int n = 0; n < 4; n++)
			begin
				if (mode == 0)
					w[n*4 +: 4] = 4'(((i * 4 + n) % 15) + 1);  // never zero
				else if (mode == 2 && rand_bits(1) == 0)
					w[n*4 +: 4] = 4'd0;
			end
			a      = 16'(rand_bits(16));  // high bits must wrap away
			a[9:0] = i[9:0];
			step_pixel(1'b0, 6'd0, 16'd0, 1'b1, a, w);
		end
	endtask

	task automatic config_sprite(input int idx, input int lo, input int pbits, input logic stride,
		input logic near_top);
		int x, y;
		logic [15:0] base, flags;
		x     = lo + rand_bits(pbits);
		y     = lo + rand_bits(pbits);
		base  = 16'(rand_bits(16));
		flags = 16'(rand_bits(16));
		flags[3] = stride;
		flags[0] = 1'b1;
		if (near_top)
			base[15:5] = 11'h7FF;  // rows run past the 18-bit wrap
		write_reg(idx, sprite_pkg::REG_X, coord_word(x));
		write_reg(idx, sprite_pkg::REG_Y, coord_word(y));
		write_reg(idx, sprite_pkg::REG_X_END, coord_word(x + 8 + rand_bits(6)));  // may pass 64
		write_reg(idx, sprite_pkg::REG_Y_END, coord_word(y + 8 + rand_bits(6)));
		write_reg(idx, sprite_pkg::REG_BASE, base);
		write_reg(idx, sprite_pkg::REG_PAL_HI, 16'(rand_bits(16)));
		write_reg(idx, sprite_pkg::REG_FLAGS, flags);
	endtask

	task automatic end_test(input string name);
		$display("test %s done: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	// ####################################################################
	// test sequence
	// ####################################################################
	initial
	begin
		RSTb = 1'b0;
		WR = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		MEM_WR = 1'b0;
		MEM_ADDR = '0;
		MEM_DATA = '0;
		display_x = '0;
		display_y = '0;
		{checks, errors, mark_checks, mark_errors} = '0;
		for (int i = 0; i < `SPR_NUM; i++)
		begin
			{m_x[i], m_y[i], m_xe[i], m_ye[i], m_base[i]} = '0;
			m_flags[i] = '0;
			m_pal[i]   = '0;
		end
		repeat (8) @(negedge CLK);
		RSTb = 1'b1;

		coord_bits = 10;
		repeat (200) idle_pixel();
		end_test("reset idle");

		coord_bits = 7;  // raster window around the sprites
		fill_mem(0);
		config_sprite(0, 0, 6, rand_bits(1), 1'b0);
		repeat (500) idle_pixel();
		end_test("single sprite bounds");

		fill_mem(1);
		config_sprite(0, 0, 6, 1'b0, 1'b0);
		repeat (300) idle_pixel();
		config_sprite(0, 0, 6, 1'b1, 1'b1);
		repeat (300) idle_pixel();
		end_test("addressing and stride");

		fill_mem(2);
		config_sprite(0, 32, 3, rand_bits(1), 1'b0);  // always overlapping
		config_sprite(1, 32, 3, rand_bits(1), 1'b0);
		repeat (400) idle_pixel();
		end_test("transparency");

		for (int i = 0; i < `SPR_NUM; i++)
			config_sprite(i, 16, 5, rand_bits(1), 1'b0);
		repeat (500) idle_pixel();
		end_test("priority");

		for (int n = 0; n < 400; n++)
		begin
			if (n == 100)
			begin
				for (int s = 7; s < 16; s++)
					write_reg(rand_bits(2), s, 16'(rand_bits(16)));
			end
			if (n == 200)
				write_reg(0, sprite_pkg::REG_FLAGS, 16'h0008);  // enable off
			if (n == 300)
				write_reg(2, sprite_pkg::REG_FLAGS, 16'h0000);
			idle_pixel();
		end
		repeat (3) idle_pixel();  // drain the pipeline
		end_test("disable and unused slots");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sprite_engine.f
+incdir+rtl
rtl/sprite_pkg.sv
rtl/sprite_cfg_if.sv
rtl/sprite_regs.sv
rtl/sprite_locate.sv
rtl/sprite_pixel_mem.sv
rtl/sprite_mixer.sv
rtl/sprite_engine.sv
verif/sprite_engine_tb.sv

//--- Bender.yml
package:
  name: sprite_engine

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sprite_pkg.sv
      - rtl/sprite_cfg_if.sv
      - rtl/sprite_regs.sv
      - rtl/sprite_locate.sv
      - rtl/sprite_pixel_mem.sv
      - rtl/sprite_mixer.sv
      - rtl/sprite_engine.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/sprite_engine_tb.sv
